// ==== im2col_params.svh ====
//==========================================================================
// geometry, kernel, stride and padding of the im2col unit
// included by the packages and by every module that needs the sizes
// the output size and vector length must agree with the input, kernel,
// stride and padding values given here
//==========================================================================
`ifndef IM2COL_PARAMS_SVH
`define IM2COL_PARAMS_SVH

`define IM2COL_QW    8
`define IM2COL_CBN   2
`define IM2COL_CBD   32

`define IM2COL_IFX   4
`define IM2COL_IFY   4
`define IM2COL_ICH   2

`define IM2COL_KX    2
`define IM2COL_KY    2
`define IM2COL_SX    1
`define IM2COL_SY    1

`define IM2COL_PADL  1
`define IM2COL_PADR  1
`define IM2COL_PADU  1
`define IM2COL_PADD  1

`define IM2COL_OFX   5
`define IM2COL_OFY   5

// kernel x times kernel y times input channels
`define IM2COL_XH    8

`endif

// ==== im2col_data_pkg.sv ====
//==========================================================================
// datapath types of the im2col unit
// shared by the activation buffer, the window fetch and the vector stage
//==========================================================================
`default_nettype none

`include "im2col_params.svh"

package im2col_data_pkg;

    localparam int BANK_BITS = $clog2(`IM2COL_CBN);
    localparam int ROW_BITS  = $clog2(`IM2COL_CBD);
    localparam int BUF_WORDS = `IM2COL_CBN * `IM2COL_CBD;
    // elements gathered by one fetch slice per vector
    localparam int SLICE_LEN = `IM2COL_XH / `IM2COL_CBN;

    typedef logic [`IM2COL_QW-1:0] pixel_t;
    // low BANK_BITS select the bank, the rest is the row inside it
    typedef logic [BANK_BITS+ROW_BITS-1:0] buf_addr_t;
    typedef logic [`IM2COL_CBN-1:0] bank_mask_t;
    typedef logic [$clog2(SLICE_LEN)-1:0] elem_idx_t;

endpackage

`default_nettype wire

// ==== im2col_ctrl_pkg.sv ====
//==========================================================================
// control state encodings of the im2col unit
// frame state lives in the buffer, fill state in the window fetch
//==========================================================================
`default_nettype none

package im2col_ctrl_pkg;

    // BUSY blocks input writes until the last vector of the frame is done
    typedef enum logic {
        OKAY = 1'b0,
        BUSY = 1'b1
    } frame_state_e;

    // FILL gathers one vector, WAIT holds for a free slot and for data
    typedef enum logic {
        WAIT = 1'b0,
        FILL = 1'b1
    } fill_state_e;

endpackage

`default_nettype wire

// ==== conv_buffer.sv ====
//==========================================================================
// banked activation buffer of the im2col unit
// accepts one word per valid/ready beat in channel, x, y order, writes it
// into the interleaved banks and throttles input on a full buffer or
// while the current frame is still being gathered
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module conv_buffer
    import im2col_data_pkg::*;
    import im2col_ctrl_pkg::*;
(
    input  wire        clk_bufr,
    input  wire        rstn_bufr,
    input  wire pixel_t data_i,
    input  wire        valid_i,
    output logic       ready_o,
    input  wire buf_addr_t bank_raddr_i [`IM2COL_CBN],
    output pixel_t     bank_dout_o [`IM2COL_CBN],
    output buf_addr_t  wr_addr_o,
    output logic       wr_wrap_o,
    input  wire buf_addr_t hold_addr_i,
    input  wire        hold_wrap_i,
    input  wire        frame_done_i
);

    frame_state_e frame_state;

    logic [$clog2(`IM2COL_ICH)-1:0] if_ch;
    logic [$clog2(`IM2COL_IFX)-1:0] if_x;
    logic [$clog2(`IM2COL_IFY)-1:0] if_y;

    logic accept;
    logic last_word;
    int   wr_cnt;
    bank_mask_t bank_we;

    pixel_t bank_mem [`IM2COL_CBN][`IM2COL_CBD];

    assign accept    = valid_i && ready_o;
    assign last_word = (if_ch == `IM2COL_ICH - 1) && (if_x == `IM2COL_IFX - 1) &&
                       (if_y == `IM2COL_IFY - 1);

    // counters stop on the last word, so BUSY adds one to point past it
    always_comb begin
        wr_cnt = int'(if_ch) + (int'(if_x) + int'(if_y) * `IM2COL_IFX) * `IM2COL_ICH;
        if (frame_state == BUSY) begin
            wr_cnt = wr_cnt + 1;
        end
        wr_addr_o = buf_addr_t'(wr_cnt % BUF_WORDS);
        wr_wrap_o = ((wr_cnt / BUF_WORDS) % 2) == 1;
    end

    // full when the writer has lapped the oldest retained word
    assign ready_o = (frame_state == OKAY) &&
                     !((wr_addr_o == hold_addr_i) && (wr_wrap_o != hold_wrap_i));

    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            if_ch <= '0;
            if_x  <= '0;
            if_y  <= '0;
        end else if (frame_done_i) begin
            if_ch <= '0;
            if_x  <= '0;
            if_y  <= '0;
        end else if (accept && !last_word) begin
            if (if_ch == `IM2COL_ICH - 1) begin
                if_ch <= '0;
                if (if_x == `IM2COL_IFX - 1) begin
                    if_x <= '0;
                    if_y <= if_y + 1'b1;
                end else begin
                    if_x <= if_x + 1'b1;
                end
            end else begin
                if_ch <= if_ch + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            frame_state <= OKAY;
        end else begin
            case (frame_state)
                OKAY: begin
                    if (accept && last_word) begin
                        frame_state <= BUSY;
                    end
                end
                BUSY: begin
                    if (frame_done_i) begin
                        frame_state <= OKAY;
                    end
                end
                default: begin
                    frame_state <= OKAY;
                end
            endcase
        end
    end

    always_comb begin
        for (int b = 0; b < `IM2COL_CBN; b++) begin
            bank_we[b] = accept && (wr_addr_o[BANK_BITS-1:0] == BANK_BITS'(b));
        end
    end

    always_ff @(posedge clk_bufr) begin
        for (int b = 0; b < `IM2COL_CBN; b++) begin
            if (bank_we[b]) begin
                bank_mem[b][wr_addr_o[BANK_BITS +: ROW_BITS]] <= data_i;
            end
        end
    end

    // banks read combinationally, one address per bank from the crossbar
    always_comb begin
        for (int b = 0; b < `IM2COL_CBN; b++) begin
            bank_dout_o[b] = bank_mem[b][bank_raddr_i[b][BANK_BITS +: ROW_BITS]];
        end
    end

endmodule

`default_nettype wire

// ==== bank_arbiter.sv ====
//==========================================================================
// round-robin arbiter with a one-hot grant
// one instance per buffer bank picks a single requesting fetch slice,
// starting the search just past the previous winner
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module bank_arbiter #(
    parameter int LEN = 2
) (
    input  wire            clk_bufr,
    input  wire            rstn_bufr,
    input  wire [LEN-1:0]  req_i,
    output logic [LEN-1:0] gnt_o
);

    localparam int PW = (LEN > 1) ? $clog2(LEN) : 1;

    logic [PW-1:0] last_q;
    logic [PW-1:0] win;
    logic          found;

    always_comb begin
        int idx;
        gnt_o = '0;
        found = 1'b0;
        win   = last_q;
        for (int i = 1; i <= LEN; i++) begin
            idx = (int'(last_q) + i) % LEN;
            if (!found && req_i[idx]) begin
                gnt_o[idx] = 1'b1;
                found      = 1'b1;
                win        = PW'(idx);
            end
        end
    end

    // index 0 has top priority after reset
    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            last_q <= PW'(LEN - 1);
        end else if (found) begin
            last_q <= win;
        end
    end

endmodule

`default_nettype wire

// ==== window_fetch.sv ====
//==========================================================================
// window fetch of the im2col unit
// walks the output positions in raster order and, once the window data is
// in the buffer, gathers one vector through per-bank arbitration with
// channel fastest, then kernel x, then kernel y inside the window
// padding positions are written as zero without touching the banks
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module window_fetch
    import im2col_data_pkg::*;
    import im2col_ctrl_pkg::*;
(
    input  wire        clk_bufr,
    input  wire        rstn_bufr,
    input  wire buf_addr_t wr_addr_i,
    input  wire        wr_wrap_i,
    input  wire pixel_t bank_dout_i [`IM2COL_CBN],
    output buf_addr_t  bank_raddr_o [`IM2COL_CBN],
    output buf_addr_t  hold_addr_o,
    output logic       hold_wrap_o,
    output logic       frame_done_o,
    input  wire        slot_free_i,
    output bank_mask_t elem_we_o,
    output elem_idx_t  elem_idx_o [`IM2COL_CBN],
    output pixel_t     elem_data_o [`IM2COL_CBN],
    output logic       vec_done_o
);

    fill_state_e fill_state;

    logic [$clog2(`IM2COL_OFX)-1:0] of_x;
    logic [$clog2(`IM2COL_OFX)-1:0] nxt_of_x;
    logic [$clog2(`IM2COL_OFY)-1:0] of_y;
    logic [$clog2(`IM2COL_OFY)-1:0] nxt_of_y;

    buf_addr_t  want_addr;
    logic       want_wrap;
    logic       win_ready;

    elem_idx_t  elem_cnt [`IM2COL_CBN];
    bank_mask_t slice_done;
    bank_mask_t slice_pad;
    bank_mask_t slice_gnt;
    bank_mask_t advance;
    buf_addr_t  slice_addr [`IM2COL_CBN];
    bank_mask_t slice_req [`IM2COL_CBN];
    pixel_t     slice_data [`IM2COL_CBN];
    bank_mask_t arb_req [`IM2COL_CBN];
    bank_mask_t arb_gnt [`IM2COL_CBN];

    buf_addr_t  next_base;
    logic       next_base_wrap;
    logic       next_base_pad;

    // last input word that the current window needs, clipped at the
    // right and bottom padding
    always_comb begin
        int lx;
        int ly;
        int flat;
        lx = int'(of_x) * `IM2COL_SX + `IM2COL_KX - 1;
        if (lx > `IM2COL_PADL + `IM2COL_IFX - 1) begin
            lx = `IM2COL_PADL + `IM2COL_IFX - 1;
        end
        ly = int'(of_y) * `IM2COL_SY + `IM2COL_KY - 1;
        if (ly > `IM2COL_PADU + `IM2COL_IFY - 1) begin
            ly = `IM2COL_PADU + `IM2COL_IFY - 1;
        end
        flat = (lx - `IM2COL_PADL + (ly - `IM2COL_PADU) * `IM2COL_IFX + 1) * `IM2COL_ICH - 1;
        want_addr = buf_addr_t'(flat % BUF_WORDS);
        want_wrap = ((flat / BUF_WORDS) % 2) == 1;
    end

    // wr_addr_i points at the next free word, so the wanted one is
    // already written when it lies below it
    assign win_ready = (want_wrap == wr_wrap_i) ? (wr_addr_i > want_addr) :
                                                  (want_addr >= wr_addr_i);

    assign vec_done_o   = (fill_state == FILL) && (&slice_done);
    assign frame_done_o = vec_done_o && (of_x == `IM2COL_OFX - 1) && (of_y == `IM2COL_OFY - 1);

    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            fill_state <= WAIT;
        end else begin
            case (fill_state)
                WAIT: begin
                    if (slot_free_i && win_ready) begin
                        fill_state <= FILL;
                    end
                end
                FILL: begin
                    if (vec_done_o) begin
                        fill_state <= WAIT;
                    end
                end
                default: begin
                    fill_state <= WAIT;
                end
            endcase
        end
    end

    // each slice maps its element counter to a window offset
    always_comb begin
        int e;
        int ch;
        int kx;
        int ky;
        int px;
        int py;
        int flat;
        for (int s = 0; s < `IM2COL_CBN; s++) begin
            e  = s * SLICE_LEN + int'(elem_cnt[s]);
            ch = e % `IM2COL_ICH;
            kx = (e / `IM2COL_ICH) % `IM2COL_KX;
            ky = e / (`IM2COL_ICH * `IM2COL_KX);
            px = int'(of_x) * `IM2COL_SX + kx - `IM2COL_PADL;
            py = int'(of_y) * `IM2COL_SY + ky - `IM2COL_PADU;
            slice_pad[s] = (px < 0) || (px >= `IM2COL_IFX) || (py < 0) || (py >= `IM2COL_IFY);
            flat = ch + (px + py * `IM2COL_IFX) * `IM2COL_ICH;
            slice_addr[s] = buf_addr_t'(flat % BUF_WORDS);
            slice_req[s]  = '0;
            if ((fill_state == FILL) && !slice_done[s] && !slice_pad[s]) begin
                slice_req[s] = bank_mask_t'(1) << slice_addr[s][BANK_BITS-1:0];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `IM2COL_CBN; b++) begin
            for (int s = 0; s < `IM2COL_CBN; s++) begin
                arb_req[b][s] = slice_req[s][b];
            end
        end
    end

    for (genvar b = 0; b < `IM2COL_CBN; b++) begin : g_bank
        bank_arbiter #(
            .LEN       (`IM2COL_CBN)
        ) i_arb (
            .clk_bufr  (clk_bufr),
            .rstn_bufr (rstn_bufr),
            .req_i     (arb_req[b]),
            .gnt_o     (arb_gnt[b])
        );
    end

    // crossbar, winning address to each bank and bank data back to the slice
    always_comb begin
        slice_gnt = '0;
        for (int s = 0; s < `IM2COL_CBN; s++) begin
            slice_data[s] = '0;
        end
        for (int b = 0; b < `IM2COL_CBN; b++) begin
            bank_raddr_o[b] = '0;
            for (int s = 0; s < `IM2COL_CBN; s++) begin
                if (arb_gnt[b][s]) begin
                    bank_raddr_o[b] = slice_addr[s];
                    slice_data[s]   = bank_dout_i[b];
                    slice_gnt[s]    = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < `IM2COL_CBN; s++) begin
            advance[s] = (fill_state == FILL) && !slice_done[s] && (slice_pad[s] || slice_gnt[s]);
            elem_idx_o[s]  = elem_cnt[s];
            elem_data_o[s] = slice_pad[s] ? '0 : slice_data[s];
        end
    end

    assign elem_we_o = advance;

    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            slice_done <= '0;
            for (int s = 0; s < `IM2COL_CBN; s++) begin
                elem_cnt[s] <= '0;
            end
        end else if (vec_done_o) begin
            slice_done <= '0;
            for (int s = 0; s < `IM2COL_CBN; s++) begin
                elem_cnt[s] <= '0;
            end
        end else begin
            for (int s = 0; s < `IM2COL_CBN; s++) begin
                if (advance[s]) begin
                    if (int'(elem_cnt[s]) == SLICE_LEN - 1) begin
                        slice_done[s] <= 1'b1;
                    end else begin
                        elem_cnt[s] <= elem_cnt[s] + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        nxt_of_x = of_x;
        nxt_of_y = of_y;
        if (vec_done_o) begin
            if (of_x == `IM2COL_OFX - 1) begin
                nxt_of_x = '0;
                nxt_of_y = (of_y == `IM2COL_OFY - 1) ? '0 : of_y + 1'b1;
            end else begin
                nxt_of_x = of_x + 1'b1;
            end
        end
    end

    // top-left corner of the next window, used to release older words
    always_comb begin
        int bx;
        int by;
        int flat;
        bx = int'(nxt_of_x) * `IM2COL_SX - `IM2COL_PADL;
        by = int'(nxt_of_y) * `IM2COL_SY - `IM2COL_PADU;
        next_base_pad = (bx < 0) || (bx >= `IM2COL_IFX) || (by < 0) || (by >= `IM2COL_IFY);
        flat = (bx + by * `IM2COL_IFX) * `IM2COL_ICH;
        next_base      = buf_addr_t'(flat % BUF_WORDS);
        next_base_wrap = ((flat / BUF_WORDS) % 2) == 1;
    end

    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            of_x        <= '0;
            of_y        <= '0;
            hold_addr_o <= '0;
            hold_wrap_o <= 1'b0;
        end else begin
            of_x <= nxt_of_x;
            of_y <= nxt_of_y;
            if (frame_done_o) begin
                hold_addr_o <= '0;
                hold_wrap_o <= 1'b0;
            end else if (vec_done_o && !next_base_pad) begin
                hold_addr_o <= next_base;
                hold_wrap_o <= next_base_wrap;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vector_pingpong.sv ====
//==========================================================================
// ping-pong vector registers of the im2col unit
// the fetch fills the write-side register while the consumer holds the
// read-side one, valid_o stays high until the ack_i strobe retires it
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module vector_pingpong
    import im2col_data_pkg::*;
(
    input  wire        clk_bufr,
    input  wire        rstn_bufr,
    input  wire bank_mask_t elem_we_i,
    input  wire elem_idx_t  elem_idx_i [`IM2COL_CBN],
    input  wire pixel_t     elem_data_i [`IM2COL_CBN],
    input  wire        vec_done_i,
    output logic       slot_free_o,
    output pixel_t     data_o [`IM2COL_XH],
    output logic       valid_o,
    input  wire        ack_i
);

    pixel_t     vec_q [2][`IM2COL_XH];
    logic [1:0] vec_valid;
    logic       wr_sel;
    logic       rd_sel;

    assign slot_free_o = !vec_valid[wr_sel];
    assign valid_o     = vec_valid[rd_sel];

    always_comb begin
        for (int i = 0; i < `IM2COL_XH; i++) begin
            data_o[i] = vec_q[rd_sel][i];
        end
    end

    // slice s owns elements s*SLICE_LEN up to the next slice
    always_ff @(posedge clk_bufr) begin
        for (int s = 0; s < `IM2COL_CBN; s++) begin
            if (elem_we_i[s]) begin
                vec_q[wr_sel][s * SLICE_LEN + int'(elem_idx_i[s])] <= elem_data_i[s];
            end
        end
    end

    // a finishing fill and an ack never touch the same register
    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            vec_valid <= '0;
            wr_sel    <= 1'b0;
            rd_sel    <= 1'b0;
        end else begin
            if (vec_done_i) begin
                vec_valid[wr_sel] <= 1'b1;
                wr_sel            <= !wr_sel;
            end
            if (ack_i && valid_o) begin
                vec_valid[rd_sel] <= 1'b0;
                rd_sel            <= !rd_sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== conv_im2col.sv ====
//==========================================================================
// im2col unit for a crossbar convolution engine
// takes activations one per valid/ready beat and emits one crossbar input
// vector per output position, held on data_o until ack_i
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module conv_im2col
    import im2col_data_pkg::*;
(
    input  wire        clk_bufr,
    input  wire        rstn_bufr,
    input  wire pixel_t data_i,
    input  wire        valid_i,
    output logic       ready_o,
    output pixel_t     data_o [`IM2COL_XH],
    output logic       valid_o,
    input  wire        ack_i
);

    buf_addr_t  bank_raddr [`IM2COL_CBN];
    pixel_t     bank_dout [`IM2COL_CBN];
    buf_addr_t  wr_addr;
    logic       wr_wrap;
    buf_addr_t  hold_addr;
    logic       hold_wrap;
    logic       frame_done;
    logic       slot_free;
    bank_mask_t elem_we;
    elem_idx_t  elem_idx [`IM2COL_CBN];
    pixel_t     elem_data [`IM2COL_CBN];
    logic       vec_done;

    conv_buffer i_buffer (
        .clk_bufr     (clk_bufr),
        .rstn_bufr    (rstn_bufr),
        .data_i       (data_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .bank_raddr_i (bank_raddr),
        .bank_dout_o  (bank_dout),
        .wr_addr_o    (wr_addr),
        .wr_wrap_o    (wr_wrap),
        .hold_addr_i  (hold_addr),
        .hold_wrap_i  (hold_wrap),
        .frame_done_i (frame_done)
    );

    window_fetch i_fetch (
        .clk_bufr     (clk_bufr),
        .rstn_bufr    (rstn_bufr),
        .wr_addr_i    (wr_addr),
        .wr_wrap_i    (wr_wrap),
        .bank_dout_i  (bank_dout),
        .bank_raddr_o (bank_raddr),
        .hold_addr_o  (hold_addr),
        .hold_wrap_o  (hold_wrap),
        .frame_done_o (frame_done),
        .slot_free_i  (slot_free),
        .elem_we_o    (elem_we),
        .elem_idx_o   (elem_idx),
        .elem_data_o  (elem_data),
        .vec_done_o   (vec_done)
    );

    vector_pingpong i_vector (
        .clk_bufr     (clk_bufr),
        .rstn_bufr    (rstn_bufr),
        .elem_we_i    (elem_we),
        .elem_idx_i   (elem_idx),
        .elem_data_i  (elem_data),
        .vec_done_i   (vec_done),
        .slot_free_o  (slot_free),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .ack_i        (ack_i)
    );

endmodule

`default_nettype wire

// ==== conv_im2col_assertions.sv ====
//==========================================================================
// concurrent checks on the im2col unit, bound into its top level
// covers reset of the output handshake, output stability and the input
// throttle during a busy frame
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module conv_im2col_assertions
    import im2col_data_pkg::*;
(
    input wire         clk_bufr,
    input wire         rstn_bufr,
    input wire         in_valid_i,
    input wire         ready_i,
    input wire         out_valid_i,
    input wire         ack_i,
    input wire pixel_t out_data_i [`IM2COL_XH],
    input wire         frame_done_i
);

    localparam int FRAME_WORDS = `IM2COL_IFX * `IM2COL_IFY * `IM2COL_ICH;

    logic [`IM2COL_XH*`IM2COL_QW-1:0] data_flat;
    int   words_in;
    logic frame_busy;

    always_comb begin
        for (int i = 0; i < `IM2COL_XH; i++) begin
            data_flat[i*`IM2COL_QW +: `IM2COL_QW] = out_data_i[i];
        end
    end

    // the frame is busy from the cycle after its last input word until the
    // cycle after frame_done
    always_ff @(posedge clk_bufr or negedge rstn_bufr) begin
        if (!rstn_bufr) begin
            words_in   <= 0;
            frame_busy <= 1'b0;
        end else begin
            if (in_valid_i && ready_i) begin
                if (words_in == FRAME_WORDS - 1) begin
                    words_in   <= 0;
                    frame_busy <= 1'b1;
                end else begin
                    words_in <= words_in + 1;
                end
            end
            if (frame_done_i) begin
                frame_busy <= 1'b0;
            end
        end
    end

    valid_low_in_reset: assert property (@(posedge clk_bufr) !rstn_bufr |-> !out_valid_i)
        else $error("valid_o is high while reset is asserted");

    // a vector that is not acknowledged stays on the output unchanged
    vector_held: assert property (@(posedge clk_bufr) disable iff (!rstn_bufr)
        (out_valid_i && !ack_i) |=> (out_valid_i && $stable(data_flat)))
        else $error("output vector changed or dropped before ack_i");

    ready_low_when_busy: assert property (@(posedge clk_bufr) disable iff (!rstn_bufr)
        frame_busy |-> !ready_i)
        else $error("ready_o is high during a busy frame");

endmodule

bind conv_im2col conv_im2col_assertions i_assertions (
    .clk_bufr     (clk_bufr),
    .rstn_bufr    (rstn_bufr),
    .in_valid_i   (valid_i),
    .ready_i      (ready_o),
    .out_valid_i  (valid_o),
    .ack_i        (ack_i),
    .out_data_i   (data_o),
    .frame_done_i (frame_done)
);

`default_nettype wire

// ==== tb_conv_im2col.sv ====
//==========================================================================
// testbench for the im2col unit
// streams the frames listed in the stimulus file into the DUT, holds
// ack_i back by the per-frame delay and checks every output vector
// against a reference im2col model of the same frame
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "im2col_params.svh"

module tb_conv_im2col
    import im2col_data_pkg::*;
;

    localparam int FRAME_WORDS = `IM2COL_IFX * `IM2COL_IFY * `IM2COL_ICH;
    localparam int POSITIONS   = `IM2COL_OFX * `IM2COL_OFY;
    localparam int RESET_CYCLES = 8;

    logic   clk_bufr;
    logic   rstn_bufr;
    pixel_t data_i;
    logic   valid_i;
    logic   ready_o;
    pixel_t data_o [`IM2COL_XH];
    logic   valid_o;
    logic   ack_i;

    int frame_base[$];
    int frame_delay[$];
    int cycle_count;
    int cycle_limit;
    logic limit_set;
    logic saw_ready_low;

    conv_im2col i_conv_im2col (
        .clk_bufr  (clk_bufr),
        .rstn_bufr (rstn_bufr),
        .data_i    (data_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .data_o    (data_o),
        .valid_o   (valid_o),
        .ack_i     (ack_i)
    );

    initial begin
        clk_bufr = 1'b0;
        forever #10 clk_bufr = ~clk_bufr;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0t ns: %s got %02h expected %02h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                        $time, what, got, exp));
        end
    endtask

    // element e of the window at output (ox, oy) takes channel fastest,
    // then kernel x, then kernel y, and reads zero outside the input map
    function automatic pixel_t expected_pixel(input int base, input int ox, input int oy,
                                              input int e);
        int ch;
        int kx;
        int ky;
        int px;
        int py;
        ch = e % `IM2COL_ICH;
        kx = (e / `IM2COL_ICH) % `IM2COL_KX;
        ky = e / (`IM2COL_ICH * `IM2COL_KX);
        px = ox * `IM2COL_SX + kx - `IM2COL_PADL;
        py = oy * `IM2COL_SY + ky - `IM2COL_PADU;
        if ((px < 0) || (px >= `IM2COL_IFX) || (py < 0) || (py >= `IM2COL_IFY)) begin
            return '0;
        end
        return pixel_t'((base + ch + (px + py * `IM2COL_IFX) * `IM2COL_ICH) % 256);
    endfunction

    task automatic read_stimulus();
        int    fd;
        int    base;
        int    delay;
        int    n;
        string line;
        fd = $fopen("conv_im2col_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the stimulus file conv_im2col_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if ((n > 0) && (line.getc(0) != "#")) begin
                    if ($sscanf(line, "%h %d", base, delay) == 2) begin
                        frame_base.push_back(base);
                        frame_delay.push_back(delay);
                    end
                end
            end
            $fclose(fd);
            if (frame_base.size() == 0) begin
                stop_with_failure("the stimulus file holds no frames");
            end
        end
    endtask

    // ready_o is sampled mid-cycle and the word moves on the next rising edge
    task automatic send_word(input pixel_t value);
        @(posedge clk_bufr);
        data_i  <= value;
        valid_i <= 1'b1;
        @(negedge clk_bufr);
        while (!ready_o) begin
            @(negedge clk_bufr);
        end
    endtask

    task automatic drive_frames();
        for (int f = 0; f < frame_base.size(); f++) begin
            for (int idx = 0; idx < FRAME_WORDS; idx++) begin
                send_word(pixel_t'((frame_base[f] + idx) % 256));
            end
        end
        @(posedge clk_bufr);
        valid_i <= 1'b0;
        data_i  <= '0;
    endtask

    task automatic wait_vector();
        @(negedge clk_bufr);
        while (!valid_o) begin
            @(negedge clk_bufr);
        end
    endtask

    task automatic acknowledge_vector(input int delay);
        repeat (delay) @(posedge clk_bufr);
        @(posedge clk_bufr);
        ack_i <= 1'b1;
        @(posedge clk_bufr);
        ack_i <= 1'b0;
    endtask

    task automatic collect_frames();
        for (int f = 0; f < frame_base.size(); f++) begin
            for (int oy = 0; oy < `IM2COL_OFY; oy++) begin
                for (int ox = 0; ox < `IM2COL_OFX; ox++) begin
                    wait_vector();
                    for (int e = 0; e < `IM2COL_XH; e++) begin
                        check_pixel(data_o[e], expected_pixel(frame_base[f], ox, oy, e),
                                    $sformatf("frame %0d position (%0d,%0d) element %0d",
                                              f, ox, oy, e));
                    end
                    acknowledge_vector(frame_delay[f]);
                end
            end
        end
    endtask

    always @(posedge clk_bufr) begin
        cycle_count = cycle_count + 1;
        if (limit_set && (cycle_count > cycle_limit)) begin
            stop_with_failure($sformatf("timeout after %0d cycles with vectors still missing",
                                        cycle_count));
        end
    end

    always @(negedge clk_bufr) begin
        if (rstn_bufr && valid_i && !ready_o) begin
            saw_ready_low = 1'b1;
        end
    end

    initial begin
        data_i        = '0;
        valid_i       = 1'b0;
        ack_i         = 1'b0;
        rstn_bufr     = 1'b0;
        cycle_count   = 0;
        cycle_limit   = RESET_CYCLES;
        limit_set     = 1'b0;
        saw_ready_low = 1'b0;
        read_stimulus();
        for (int f = 0; f < frame_base.size(); f++) begin
            cycle_limit = cycle_limit + POSITIONS * (frame_delay[f] + 40);
        end
        limit_set = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_bufr);
        rstn_bufr <= 1'b1;
        @(negedge clk_bufr);
        check_level(valid_o, 1'b0, "valid_o after reset");
        check_level(ready_o, 1'b1, "ready_o after reset");
        fork
            drive_frames();
            collect_frames();
        join
        if (!saw_ready_low) begin
            stop_with_failure("ready_o never fell while input words were waiting");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== conv_im2col_stimulus.txt ====
# columns: pixel base value in hex, ack_i delay in cycles
# one frame per line, frames run in file order
00 0
3c 1
a7 2
f0 0
11 60
5e 3
c8 0
81 12
29 5
e4 1

// ==== files.f ====
+incdir+.
im2col_data_pkg.sv
im2col_ctrl_pkg.sv
conv_buffer.sv
bank_arbiter.sv
window_fetch.sv
vector_pingpong.sv
conv_im2col.sv
conv_im2col_assertions.sv
tb_conv_im2col.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_conv_im2col -o sim_tb
out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"
if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
echo "simulation failed"
exit 1
